/* hw/aluPkg.sv */
/* ALU types shared by the execute stage
   opcodes, condition codes, flags, instruction word and result */

`include "execute_cfg.svh"

package aluPkg;

    // 1100 to 1111 are memory ops, not executed here
    typedef enum logic [3:0] {
        opAdd    = 4'b0000,
        opSub    = 4'b0001,
        opMul    = 4'b0010,
        opOr     = 4'b0011,
        opAnd    = 4'b0100,
        opXor    = 4'b0101,
        opMovImm = 4'b0110,
        opMov    = 4'b0111,
        opLsr    = 4'b1000,
        opLsl    = 4'b1001,
        opRor    = 4'b1010,
        opCmp    = 4'b1011
    } opCodeT;

    typedef enum logic [3:0] {
        condEq = 4'b0000,
        condNe = 4'b0001,
        condCs = 4'b0010,
        condCc = 4'b0011,
        condMi = 4'b0100,
        condPl = 4'b0101,
        condVs = 4'b0110,
        condVc = 4'b0111,
        condHi = 4'b1000,
        condLs = 4'b1001,
        condGe = 4'b1010,
        condLt = 4'b1011,
        condGt = 4'b1100,
        condLe = 4'b1101,
        condAl = 4'b1110,
        condNv = 4'b1111
    } condT;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flagsT;

    typedef struct packed {
        logic [10:0]             rsvd;
        logic [`SHAMT_WIDTH-1:0] amount;
    } shiftFieldT;

    // immediate for move-immediate, shift amount for the shifts
    typedef union packed {
        logic [15:0] imm16;
        shiftFieldT  shift;
    } ivWordT;

    typedef struct packed {
        opCodeT opCode;
        condT   cond;
        logic   setFlags;
        ivWordT iv;
    } aluInstrT;

    typedef struct packed {
        logic                   valid;
        logic                   wrEn;
        logic [`DATA_WIDTH-1:0] value;
    } execResultT;

endpackage

/* hw/arithUnit.sv */
/* arithmetic unit
   add, subtract, compare and multiply with NZCV */

`timescale 1ns/1ps
`include "execute_cfg.svh"

module arithUnit
    import aluPkg::*;
(
    input  opCodeT                 opCode,
    input  logic [`DATA_WIDTH-1:0] regA,
    input  logic [`DATA_WIDTH-1:0] regB,
    input  flagsT                  flagsIn,
    output logic [`DATA_WIDTH-1:0] value,
    output flagsT                  flagsOut
);

    logic                   isSub;
    logic                   isMul;
    logic [`DATA_WIDTH-1:0] opB;
    logic [`DATA_WIDTH:0]   sum;
    logic [`DATA_WIDTH-1:0] product;

    // subtract and compare share the adder as A + ~B + 1
    assign isSub = (opCode == opSub) || (opCode == opCmp);
    assign isMul = (opCode == opMul);

    assign opB = isSub ? ~regB : regB;

    // extra bit catches the carry out, which for subtract means no borrow
    assign sum = {1'b0, regA} + {1'b0, opB} + {{`DATA_WIDTH{1'b0}}, isSub};

    // low word of the product only
    assign product = regA * regB;

    always_comb
    begin
        flagsOut = flagsIn;
        if (isMul)
        begin
            value = product;
            flagsOut.n = product[`DATA_WIDTH-1];
            flagsOut.z = (product == '0);
        end
        else
        begin
            value = sum[`DATA_WIDTH-1:0];
            flagsOut.n = sum[`DATA_WIDTH-1];
            flagsOut.z = (sum[`DATA_WIDTH-1:0] == '0);
            flagsOut.c = sum[`DATA_WIDTH];
            // overflow when both inputs agree in sign and the sum does not
            flagsOut.v = (regA[`DATA_WIDTH-1] == opB[`DATA_WIDTH-1]) &&
                         (sum[`DATA_WIDTH-1] != regA[`DATA_WIDTH-1]);
        end
    end

endmodule

/* hw/condCheck.sv */
/* condition check
   decides from NZCV whether an instruction executes */

`timescale 1ns/1ps
`include "execute_cfg.svh"

module condCheck
    import aluPkg::*;
(
    input  condT  cond,
    input  flagsT flags,
    output logic  execute
);

    always_comb
    begin
        unique case (cond)
            condEq: execute = flags.z;
            condNe: execute = !flags.z;
            condCs: execute = flags.c;
            condCc: execute = !flags.c;
            condMi: execute = flags.n;
            condPl: execute = !flags.n;
            condVs: execute = flags.v;
            condVc: execute = !flags.v;
            // unsigned higher / lower or same
            condHi: execute = flags.c && !flags.z;
            condLs: execute = !flags.c || flags.z;
            // signed compares
            condGe: execute = (flags.n == flags.v);
            condLt: execute = (flags.n != flags.v);
            condGt: execute = !flags.z && (flags.n == flags.v);
            condLe: execute = flags.z || (flags.n != flags.v);
            condAl: execute = 1'b1;
            // NV never executes
            default: execute = 1'b0;
        endcase
    end

    // AL must pass whatever the flags hold
    always_comb
    begin
        if (cond == condAl)
        begin
            alwaysExec: assert final (execute)
                else $error("condCheck: AL did not execute");
        end
    end

endmodule

/* hw/executeStage.sv */
/* execute stage top
   one-cycle registered result strobe and the NZCV flag register */

`timescale 1ns/1ps
`include "execute_cfg.svh"

module executeStage
    import aluPkg::*;
(
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   issue,
    input  aluInstrT               instr,
    input  logic [`DATA_WIDTH-1:0] regA,
    input  logic [`DATA_WIDTH-1:0] regB,
    output execResultT             done,
    output flagsT                  flags
);

    logic [`DATA_WIDTH-1:0] aluResult;
    logic                   aluWrEn;
    flagsT                  nextFlags;

    // combinational datapath, works on the flags held right now
    masterAlu iAlu (
        .instr     (instr),
        .regA      (regA),
        .regB      (regB),
        .flags     (flags),
        .aluResult (aluResult),
        .aluWrEn   (aluWrEn),
        .nextFlags (nextFlags)
    );

    // result strobe, one pulse per issue
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            done <= '0;
        end
        else
        begin
            done.valid <= issue;
            done.wrEn  <= issue && aluWrEn;
            if (issue)
                done.value <= aluResult;
        end
    end

    // NZCV register, only moves on an issue
    always_ff @(posedge clk)
    begin
        if (!rstN)
            flags <= '0;
        else if (issue)
            flags <= nextFlags;
    end

    // no issue in one cycle means the flags hold through the next
    flagsHold: assert property (@(posedge clk) disable iff (!rstN)
        !issue |=> $stable(flags))
        else $error("executeStage: flags changed without an issue");

endmodule

/* hw/logicShiftUnit.sv */
/* logic and shift unit
   bitwise ops, moves and shifts of regB, with N, Z and shifter carry */

`timescale 1ns/1ps
`include "execute_cfg.svh"

module logicShiftUnit
    import aluPkg::*;
(
    input  opCodeT                 opCode,
    input  logic [`DATA_WIDTH-1:0] regB,
    input  logic [`DATA_WIDTH-1:0] regA,
    input  ivWordT                 iv,
    input  flagsT                  flagsIn,
    output logic [`DATA_WIDTH-1:0] value,
    output flagsT                  flagsOut
);

    logic [`SHAMT_WIDTH-1:0]  shAmt;
    logic                     isShift;
    logic                     isMove;
    logic                     shCarry;
    logic [`DATA_WIDTH:0]     lsrWide;
    logic [`DATA_WIDTH:0]     lslWide;
    logic [2*`DATA_WIDTH-1:0] rorWide;

    assign shAmt   = iv.shift.amount;
    assign isShift = (opCode == opLsr) || (opCode == opLsl) || (opCode == opRor);
    assign isMove  = (opCode == opMov) || (opCode == opMovImm);

    // one guard bit on each side holds the last bit shifted out
    assign lsrWide = {regB, 1'b0} >> shAmt;
    assign lslWide = {1'b0, regB} << shAmt;
    // rotate as a shift of the doubled word
    assign rorWide = {regB, regB} >> shAmt;

    always_comb
    begin
        value   = '0;
        shCarry = flagsIn.c;
        unique case (opCode)
            opOr:  value = regA | regB;
            opAnd: value = regA & regB;
            opXor: value = regA ^ regB;
            // zero extended immediate
            opMovImm: value[15:0] = iv.imm16;
            opMov: value = regB;
            opLsr:
            begin
                value   = lsrWide[`DATA_WIDTH:1];
                shCarry = lsrWide[0];
            end
            opLsl:
            begin
                value   = lslWide[`DATA_WIDTH-1:0];
                shCarry = lslWide[`DATA_WIDTH];
            end
            opRor:
            begin
                value   = rorWide[`DATA_WIDTH-1:0];
                shCarry = rorWide[`DATA_WIDTH-1];
            end
            default: value = '0;
        endcase
    end

    // v always passes through, moves leave everything alone
    always_comb
    begin
        flagsOut = flagsIn;
        if (!isMove)
        begin
            flagsOut.n = value[`DATA_WIDTH-1];
            flagsOut.z = (value == '0);
        end
        // shift by 0 keeps C
        if (isShift && (shAmt != '0))
            flagsOut.c = shCarry;
    end

    always_comb
    begin
        if (isShift && (shAmt == '0))
        begin
            zeroShift: assert final (value == regB)
                else $error("logicShiftUnit: shift by 0 altered regB");
        end
    end

endmodule

/* hw/masterAlu.sv */
/* master ALU
   opcode dispatch to the units, gated by the condition and the S bit */

`timescale 1ns/1ps
`include "execute_cfg.svh"

module masterAlu
    import aluPkg::*;
(
    input  aluInstrT               instr,
    input  logic [`DATA_WIDTH-1:0] regA,
    input  logic [`DATA_WIDTH-1:0] regB,
    input  flagsT                  flags,
    output logic [`DATA_WIDTH-1:0] aluResult,
    output logic                   aluWrEn,
    output flagsT                  nextFlags
);

    logic                   execute;
    logic                   updFlags;
    logic [`DATA_WIDTH-1:0] arithValue;
    logic [`DATA_WIDTH-1:0] logicValue;
    flagsT                  arithFlags;
    flagsT                  logicFlags;
    flagsT                  unitFlags;

    condCheck iCond (
        .cond    (instr.cond),
        .flags   (flags),
        .execute (execute)
    );

    arithUnit iArith (
        .opCode   (instr.opCode),
        .regA     (regA),
        .regB     (regB),
        .flagsIn  (flags),
        .value    (arithValue),
        .flagsOut (arithFlags)
    );

    logicShiftUnit iLogic (
        .opCode   (instr.opCode),
        .regB     (regB),
        .regA     (regA),
        .iv       (instr.iv),
        .flagsIn  (flags),
        .value    (logicValue),
        .flagsOut (logicFlags)
    );

    always_comb
    begin
        aluResult = '0;
        aluWrEn   = 1'b0;
        unitFlags = flags;
        updFlags  = 1'b0;
        unique case (instr.opCode)
            opAdd, opSub, opMul:
            begin
                aluResult = arithValue;
                aluWrEn   = execute;
                unitFlags = arithFlags;
                updFlags  = execute && instr.setFlags;
            end
            opOr, opAnd, opXor, opMovImm, opMov, opLsr, opLsl, opRor:
            begin
                aluResult = logicValue;
                aluWrEn   = execute;
                unitFlags = logicFlags;
                updFlags  = execute && instr.setFlags;
            end
            // compare sets flags even without S and writes nothing
            opCmp:
            begin
                unitFlags = arithFlags;
                updFlags  = execute;
            end
            // memory path opcodes are not executed here
            default: updFlags = 1'b0;
        endcase
        nextFlags = updFlags ? unitFlags : flags;
    end

    always_comb
    begin
        if (!execute)
        begin
            skipKeepsFlags: assert final (nextFlags == flags)
                else $error("masterAlu: flags changed on failed condition");
        end
    end

endmodule

/* include/execute_cfg.svh */
/* execute stage configuration
   operand width and shift-amount field width */

`ifndef EXECUTE_CFG_SVH
`define EXECUTE_CFG_SVH

// operand and result width
`define DATA_WIDTH 32

// shift amount field inside the IV word
`define SHAMT_WIDTH 5

`endif

/* project.f */
+incdir+include
hw/aluPkg.sv
hw/condCheck.sv
hw/arithUnit.sv
hw/logicShiftUnit.sv
hw/masterAlu.sv
hw/executeStage.sv
testbench/tbExecute.sv

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbExecute -Mdir obj_dir -f project.f
./obj_dir/VtbExecute > sim.log 2>&1
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
fi
exit 1

/* testbench/tbExecute.sv */
/* execute stage testbench
   LFSR and directed stimulus against a reference model, checked by assertions */

`timescale 1ns/1ps
`include "execute_cfg.svh"

module tbExecute
    import aluPkg::*;
();

    localparam int TimeoutCycles = 2000;

    logic                   clk;
    logic                   rstN;
    logic                   issue;
    aluInstrT               instr;
    logic [`DATA_WIDTH-1:0] regA;
    logic [`DATA_WIDTH-1:0] regB;
    execResultT             done;
    flagsT                  flags;

    logic [15:0] lfsr;
    flagsT       modelFlags;
    logic        seenIssue;
    // expected response of the instruction on the inputs now
    logic        pendWrEn;
    logic [31:0] pendValue;
    flagsT       pendFlags;
    // expected response of the instruction taken at the last edge
    logic        chkWrEn;
    logic [31:0] chkValue;
    flagsT       chkFlags;
    int          cycles = 0;
    int          valueErrs = 0;
    int          strobeErrs = 0;
    int          flagErrs = 0;

    executeStage i_dut (
        .clk   (clk),
        .rstN  (rstN),
        .issue (issue),
        .instr (instr),
        .regA  (regA),
        .regB  (regB),
        .done  (done),
        .flags (flags)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic randBits(input int n, output logic [31:0] r);
        int k;
        begin
            r = '0;
            for (k = 0; k < n; k++)
            begin
                lfsr = lfsrNext(lfsr);
                r = {r[30:0], lfsr[0]};
            end
        end
    endtask

    function automatic logic [31:0] cornerValue(input logic [1:0] k);
        case (k)
            2'd0:    return 32'h0000_0000;
            2'd1:    return 32'hFFFF_FFFF;
            2'd2:    return 32'h8000_0000;
            default: return 32'h7FFF_FFFF;
        endcase
    endfunction

    function automatic logic condPass(input logic [3:0] cond, input flagsT f);
        case (cond)
            4'h0:    return f.z;
            4'h1:    return !f.z;
            4'h2:    return f.c;
            4'h3:    return !f.c;
            4'h4:    return f.n;
            4'h5:    return !f.n;
            4'h6:    return f.v;
            4'h7:    return !f.v;
            4'h8:    return f.c && !f.z;
            4'h9:    return !f.c || f.z;
            4'hA:    return f.n == f.v;
            4'hB:    return f.n != f.v;
            4'hC:    return !f.z && (f.n == f.v);
            4'hD:    return f.z || (f.n != f.v);
            4'hE:    return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // reference model of one instruction
    task automatic refModel(input logic [3:0] op, input logic [3:0] cond, input logic s,
                            input logic [15:0] iv, input logic [31:0] a, input logic [31:0] b,
                            input flagsT fIn, output logic wr, output logic [31:0] val,
                            output flagsT fOut);
        logic        run;
        logic        setNz;
        logic [32:0] wide;
        logic [63:0] prod;
        logic [4:0]  amt;
        logic [4:0]  back;
        flagsT       newF;
        begin
            run   = condPass(cond, fIn);
            amt   = iv[4:0];
            back  = 5'd0 - amt;
            val   = '0;
            newF  = fIn;
            setNz = 1'b1;
            case (op)
                4'd0:
                begin
                    wide   = {1'b0, a} + {1'b0, b};
                    val    = wide[31:0];
                    newF.c = wide[32];
                    newF.v = (a[31] == b[31]) && (val[31] != a[31]);
                end
                4'd1, 4'd11:
                begin
                    val    = a - b;
                    newF.c = (a >= b);
                    newF.v = (a[31] != b[31]) && (val[31] != a[31]);
                end
                4'd2:
                begin
                    prod = {32'h0, a} * {32'h0, b};
                    val  = prod[31:0];
                end
                4'd3: val = a | b;
                4'd4: val = a & b;
                4'd5: val = a ^ b;
                4'd6:
                begin
                    val   = {16'h0, iv};
                    setNz = 1'b0;
                end
                4'd7:
                begin
                    val   = b;
                    setNz = 1'b0;
                end
                4'd8:
                begin
                    val = b >> amt;
                    if (amt != 5'd0)
                        newF.c = b[amt - 5'd1];
                end
                4'd9:
                begin
                    val = b << amt;
                    if (amt != 5'd0)
                        newF.c = b[back];
                end
                4'd10:
                begin
                    val = (b >> amt) | (b << back);
                    if (amt != 5'd0)
                        newF.c = val[31];
                end
                default: setNz = 1'b0;
            endcase
            if (setNz)
            begin
                newF.n = val[31];
                newF.z = (val == 32'h0);
            end
            wr   = run && (op <= 4'd10);
            fOut = (run && (s || op == 4'd11) && op <= 4'd11) ? newF : fIn;
        end
    endtask

    task automatic issueInstr(input logic [3:0] op, input logic [3:0] cond, input logic s,
                              input logic [15:0] iv, input logic [31:0] a,
                              input logic [31:0] b);
        begin
            instr = aluInstrT'({op, cond, s, iv});
            regA  = a;
            regB  = b;
            issue = 1'b1;
            refModel(op, cond, s, iv, a, b, modelFlags, pendWrEn, pendValue, pendFlags);
            @(posedge clk);
            #1;
            issue = 1'b0;
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // model flag register, plus what the next edge must show
    always @(posedge clk)
    begin
        if (!rstN)
        begin
            modelFlags <= '0;
            seenIssue  <= 1'b0;
            chkWrEn    <= 1'b0;
            chkValue   <= '0;
            chkFlags   <= '0;
        end
        else if (issue)
        begin
            modelFlags <= pendFlags;
            seenIssue  <= 1'b1;
            chkWrEn    <= pendWrEn;
            chkValue   <= pendValue;
            chkFlags   <= pendFlags;
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TimeoutCycles)
        begin
            $display("timeout: stimulus did not finish within %0d cycles", TimeoutCycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    resetState: assert property (@(posedge clk) disable iff (!rstN)
        !seenIssue |-> (!done.valid && flags == 4'b0000))
        else
        begin
            strobeErrs++;
            $display("ERR %0t: state after reset valid=%b flags=%b", $time,
                     $sampled(done.valid), $sampled(flags));
        end

    strobeMatch: assert property (@(posedge clk) disable iff (!rstN)
        issue |=> (done.valid && done.wrEn == chkWrEn))
        else
        begin
            strobeErrs++;
            $display("ERR %0t: valid=%b wrEn=%b, expected wrEn=%b", $time,
                     $sampled(done.valid), $sampled(done.wrEn), $sampled(chkWrEn));
        end

    idleQuiet: assert property (@(posedge clk) disable iff (!rstN)
        !issue |=> !done.valid)
        else
        begin
            strobeErrs++;
            $display("ERR %0t: valid pulse without an issue", $time);
        end

    valueMatch: assert property (@(posedge clk) disable iff (!rstN)
        issue |=> (!chkWrEn || done.value == chkValue))
        else
        begin
            valueErrs++;
            $display("ERR %0t: value %h, expected %h", $time,
                     $sampled(done.value), $sampled(chkValue));
        end

    flagsMatch: assert property (@(posedge clk) disable iff (!rstN)
        issue |=> (flags == chkFlags))
        else
        begin
            flagErrs++;
            $display("ERR %0t: flags %b, expected %b", $time,
                     $sampled(flags), $sampled(chkFlags));
        end

    initial
    begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0]  op;
        logic [3:0]  cond;
        logic        s;
        logic [15:0] iv;
        logic [31:0] cmpA [6];
        logic [31:0] cmpB [6];
        int          i;
        int          k;
        rstN  = 1'b0;
        issue = 1'b0;
        instr = '0;
        regA  = '0;
        regB  = '0;
        lfsr  = 16'd52111;
        pendWrEn  = 1'b0;
        pendValue = '0;
        pendFlags = '0;
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
        idleCycles(3);

        // carry, overflow both ways, zero results, negative products
        issueInstr(opAdd, condAl, 1'b1, 16'h0, 32'hFFFF_FFFF, 32'h1);
        issueInstr(opAdd, condAl, 1'b1, 16'h0, 32'h7FFF_FFFF, 32'h1);
        issueInstr(opAdd, condAl, 1'b1, 16'h0, 32'h8000_0000, 32'h8000_0000);
        issueInstr(opSub, condAl, 1'b1, 16'h0, 32'h5, 32'h5);
        issueInstr(opSub, condAl, 1'b1, 16'h0, 32'h0, 32'h1);
        issueInstr(opSub, condAl, 1'b1, 16'h0, 32'h8000_0000, 32'h1);
        issueInstr(opSub, condAl, 1'b1, 16'h0, 32'h7FFF_FFFF, 32'hFFFF_FFFF);
        issueInstr(opMul, condAl, 1'b1, 16'h0, 32'hFFFF_FFFF, 32'h3);
        issueInstr(opMul, condAl, 1'b1, 16'h0, 32'h0001_0000, 32'h0001_0000);
        issueInstr(opMul, condAl, 1'b1, 16'h0, 32'hFFFF_FFFB, 32'h7);

        // logic ops and moves, S set so moves must still keep the flags
        issueInstr(opOr, condAl, 1'b1, 16'h0, 32'h0, 32'h0);
        issueInstr(opAnd, condAl, 1'b1, 16'h0, 32'hF0F0_F0F0, 32'h8F0F_0F0F);
        issueInstr(opXor, condAl, 1'b1, 16'h0, 32'h1234_5678, 32'h1234_5678);
        issueInstr(opCmp, condAl, 1'b0, 16'h0, 32'h1, 32'h2);
        issueInstr(opMov, condAl, 1'b1, 16'h0, 32'h0, 32'h0);
        issueInstr(opMovImm, condAl, 1'b1, 16'hBEEF, 32'h0, 32'h0);
        issueInstr(opAdd, condAl, 1'b0, 16'h0, 32'hFFFF_FFFF, 32'h1);

        // every shift amount, and amount 0 with C both set and clear
        for (i = 0; i < 32; i++)
        begin
            b = i[0] ? 32'h5A3C_F096 : 32'hA5C3_0F69;
            issueInstr(opLsr, condAl, 1'b1, {11'h0, 5'(i)}, 32'h0, b);
            issueInstr(opLsl, condAl, 1'b1, {11'h0, 5'(i)}, 32'h0, b);
            issueInstr(opRor, condAl, 1'b1, {11'h0, 5'(i)}, 32'h0, b);
        end
        issueInstr(opCmp, condAl, 1'b0, 16'h0, 32'h5, 32'h3);
        issueInstr(opLsl, condAl, 1'b1, 16'h0, 32'h0, 32'h1);
        issueInstr(opCmp, condAl, 1'b0, 16'h0, 32'h1, 32'h2);
        issueInstr(opRor, condAl, 1'b1, 16'h0, 32'h0, 32'h8000_0000);

        // flag states from CMP, then all sixteen codes without S
        cmpA = '{32'h5, 32'h1, 32'h8000_0000, 32'h3, 32'h7FFF_FFFF, 32'h0};
        cmpB = '{32'h5, 32'h2, 32'h1, 32'h1, 32'hFFFF_FFFF, 32'h8000_0000};
        for (i = 0; i < 6; i++)
        begin
            issueInstr(opCmp, condAl, 1'b0, 16'h0, cmpA[i], cmpB[i]);
            for (k = 0; k < 16; k++)
                issueInstr(opAdd, 4'(k), 1'b0, 16'h0, 32'h10 + k, 32'h1);
            idleCycles(1);
        end

        // reserved opcodes back to back with executing ones
        for (i = 12; i < 16; i++)
        begin
            issueInstr(4'(i), condAl, 1'b1, 16'h1, 32'h0, 32'h0);
            issueInstr(opSub, condAl, 1'b1, 16'h0, 32'h0, 32'(i));
        end

        // random mix, half forced to AL, gaps of 0 to 2 cycles
        for (i = 0; i < 600; i++)
        begin
            randBits(4, r);
            op = r[3:0];
            randBits(5, r);
            cond = r[4] ? condAl : r[3:0];
            randBits(1, r);
            s = r[0];
            randBits(16, r);
            iv = r[15:0];
            randBits(32, a);
            randBits(32, b);
            randBits(4, r);
            if (r[3:2] == 2'b00)
                a = cornerValue(r[1:0]);
            randBits(4, r);
            if (r[3:2] == 2'b00)
                b = cornerValue(r[1:0]);
            issueInstr(op, cond, s, iv, a, b);
            randBits(2, r);
            if (r[1])
                idleCycles(1 + int'(r[0]));
        end

        idleCycles(3);
        $display("errors: value %0d, strobe %0d, flags %0d", valueErrs, strobeErrs, flagErrs);
        if (valueErrs + strobeErrs + flagErrs == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
